// File: dv/back_end_checker.sv
`default_nettype none

module back_end_checker
#(
    parameter int LEN    = 32,
    parameter int NB_REG = 5
)
(
    input  wire              i_clk,
    input  wire              i_exp_valid,
    input  wire [7:0]        i_exp_test,
    input  wire [LEN-1:0]    i_exp_wb_data,
    input  wire [NB_REG-1:0] i_exp_wb_reg,
    input  wire              i_exp_wb_en,
    input  wire              i_exp_pc_src,
    input  wire [LEN-1:0]    i_exp_target,
    input  wire [LEN-1:0]    i_wb_data,
    input  wire [NB_REG-1:0] i_wb_reg,
    input  wire              i_wb_en,
    input  wire              i_pc_src,
    input  wire [LEN-1:0]    i_branch_target,
    output int               o_tests_done,
    output int               o_tests_failed,
    output int               o_checks,
    output int               o_errors
);

    timeunit 1ns;
    timeprecision 1ps;

    // Expected writeback, held until the MEM/WB register catches up
    typedef struct packed {
        logic [7:0]        test;
        logic [LEN-1:0]    wb_data;
        logic [NB_REG-1:0] wb_reg;
        logic              wb_en;
        logic [7:0]        errs;
    } record_t;

    record_t pending_q [$];
    int      cur_test = -1;
    int      cur_errs = 0;

    initial
    begin
        o_tests_done   = 0;
        o_tests_failed = 0;
        o_checks       = 0;
        o_errors       = 0;
    end

    function automatic string test_name(input int id);
        case (id)
            0:       test_name = "reset_state";
            1:       test_name = "register_ops";
            2:       test_name = "immediate_ops";
            3:       test_name = "branch";
            4:       test_name = "load_store";
            5:       test_name = "forwarding";
            default: test_name = "drain";
        endcase
    endfunction

    function automatic int compare(input int id, input string field,
                                   input logic [LEN-1:0] expv, input logic [LEN-1:0] actv);
        o_checks++;
        if (actv !== expv)
        begin
            $display("Fail %s %s: expected %h, actual %h", test_name(id), field, expv, actv);
            compare = 1;
        end
        else
        begin
            compare = 0;
        end
    endfunction

    task automatic close_test();
        if (cur_errs == 0)
        begin
            $display("Test %s: no mismatches", test_name(cur_test));
        end
        else
        begin
            $display("Test %s: %0d mismatches", test_name(cur_test), cur_errs);
            o_tests_failed++;
        end
        o_tests_done++;
    endtask

    ////////////////////////////////////////////////////////////
    // Compare at every rising edge
    ////////////////////////////////////////////////////////////
    always @(posedge i_clk)
    begin
        record_t rec;
        record_t done;
        int      errs;
        // Writeback of the instruction issued two edges ago
        if (pending_q.size() > 0)
        begin
            done = pending_q.pop_front();
            if (done.test != cur_test)
            begin
                if (cur_test >= 0)
                begin
                    close_test();
                end
                cur_test = done.test;
                cur_errs = 0;
            end
            errs = done.errs;
            errs += compare(done.test, "wb_en", done.wb_en, i_wb_en);
            errs += compare(done.test, "wb_reg", done.wb_reg, i_wb_reg);
            errs += compare(done.test, "wb_data", done.wb_data, i_wb_data);
            cur_errs += errs;
            o_errors += errs;
        end
        // Branch outputs belong to the instruction issued one edge ago
        if (i_exp_valid)
        begin
            rec.test    = i_exp_test;
            rec.wb_data = i_exp_wb_data;
            rec.wb_reg  = i_exp_wb_reg;
            rec.wb_en   = i_exp_wb_en;
            rec.errs    = compare(i_exp_test, "pc_src", i_exp_pc_src, i_pc_src)
                          + compare(i_exp_test, "branch_target", i_exp_target, i_branch_target);
            pending_q.push_back(rec);
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_back_end.sv
`default_nettype none

module tb_back_end
    import mips_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LEN            = 32;
    localparam int NB_REG         = 5;
    localparam int NB_MEM_ADDR    = 6;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = 200;

    typedef struct packed {
        logic [LEN-1:0]    wb_data;
        logic [NB_REG-1:0] wb_reg;
        logic              wb_en;
        logic              pc_src;
        logic [LEN-1:0]    target;
    } expect_t;

    logic                   clk;
    logic                   rst;
    logic [LEN-1:0]         adder_id;
    logic [LEN-1:0]         dato1;
    logic [LEN-1:0]         dato2;
    logic [LEN-1:0]         sign_extend;
    logic [NB_REG-1:0]      rs;
    logic [NB_REG-1:0]      rt;
    logic [NB_REG-1:0]      rd;
    logic [NB_CTRL_EX-1:0]  ctrl_ex;
    logic [NB_CTRL_MEM-1:0] ctrl_mem;
    logic [NB_CTRL_WB-1:0]  ctrl_wb;
    logic [LEN-1:0]         wb_data;
    logic [NB_REG-1:0]      wb_reg;
    logic                   wb_en;
    logic                   pc_src;
    logic [LEN-1:0]         branch_target;
    logic                   exp_valid;
    logic [7:0]             exp_test;
    expect_t                exp;
    int                     tests_done;
    int                     tests_failed;
    int                     checks;
    int                     errors;

    // True register state and the register file that decode reads
    logic [LEN-1:0]          arch_regs [32];
    logic [LEN-1:0]          reg_file [32];
    logic [LEN-1:0]          ref_mem [2**NB_MEM_ADDR];
    logic [LEN+NB_REG:0]     lag_q [$];
    logic [31:0]             lfsr_state;
    logic [LEN-1:0]          pc;
    logic [NB_ALU_CONTROL-1:0] all_ops [10] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                                ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI};

    tl_back_end #(
        .LEN                  (LEN),
        .NB_ADDRESS_REGISTROS (NB_REG),
        .NB_MEM_ADDR          (NB_MEM_ADDR)
    ) DUT (
        .i_clk (clk), .i_rst (rst), .i_adder_id (adder_id),
        .i_dato1 (dato1), .i_dato2 (dato2), .i_sign_extend (sign_extend),
        .i_rs (rs), .i_rt (rt), .i_rd (rd),
        .i_ctrl_ex (ctrl_ex), .i_ctrl_mem (ctrl_mem), .i_ctrl_wb (ctrl_wb),
        .o_wb_data (wb_data), .o_wb_reg (wb_reg), .o_wb_en (wb_en),
        .o_pc_src (pc_src), .o_branch_target (branch_target)
    );

    back_end_checker #(
        .LEN    (LEN),
        .NB_REG (NB_REG)
    ) back_end_checker (
        .i_clk (clk), .i_exp_valid (exp_valid), .i_exp_test (exp_test),
        .i_exp_wb_data (exp.wb_data), .i_exp_wb_reg (exp.wb_reg), .i_exp_wb_en (exp.wb_en),
        .i_exp_pc_src (exp.pc_src), .i_exp_target (exp.target),
        .i_wb_data (wb_data), .i_wb_reg (wb_reg), .i_wb_en (wb_en),
        .i_pc_src (pc_src), .i_branch_target (branch_target),
        .o_tests_done (tests_done), .o_tests_failed (tests_failed),
        .o_checks (checks), .o_errors (errors)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        take_bits = bits;
    endfunction

    function automatic logic [NB_REG-1:0] rand_reg();
        logic [NB_REG-1:0] r;
        r        = NB_REG'(take_bits(NB_REG));
        rand_reg = (r == '0) ? 5'd1 : r;
    endfunction

    function automatic logic [LEN-1:0] rand_imm();
        logic [15:0] h;
        h        = 16'(take_bits(16));
        rand_imm = {{16{h[15]}}, h};
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [LEN-1:0] alu_ref(input logic [3:0] op,
                                               input logic [LEN-1:0] a, input logic [LEN-1:0] b);
        case (op)
            ALU_ADD: alu_ref = a + b;
            ALU_SUB: alu_ref = a - b;
            ALU_AND: alu_ref = a & b;
            ALU_OR:  alu_ref = a | b;
            ALU_XOR: alu_ref = a ^ b;
            ALU_NOR: alu_ref = ~(a | b);
            ALU_SLT: alu_ref = ($signed(a) < $signed(b)) ? 1 : 0;
            ALU_SLL: alu_ref = b << a[4:0];
            ALU_SRL: alu_ref = b >> a[4:0];
            ALU_LUI: alu_ref = {b[15:0], 16'h0000};
            default: alu_ref = '0;
        endcase
    endfunction

    function automatic expect_t reference(input logic [NB_CTRL_EX-1:0] cex,
                                          input logic [NB_CTRL_MEM-1:0] cmem,
                                          input logic [NB_CTRL_WB-1:0] cwb,
                                          input logic [NB_REG-1:0] s, input logic [NB_REG-1:0] t,
                                          input logic [NB_REG-1:0] d,
                                          input logic [LEN-1:0] imm, input logic [LEN-1:0] pc4);
        expect_t        e;
        logic [LEN-1:0] b;
        logic [LEN-1:0] res;
        b         = cex[EX_ALU_SRC] ? imm : arch_regs[t];
        res       = alu_ref(cex[EX_ALU_MSB:EX_ALU_LSB], arch_regs[s], b);
        e.wb_reg  = cex[EX_REG_DST] ? d : t;
        e.wb_en   = cwb[WB_REG_WRITE];
        e.wb_data = cwb[WB_MEM_TO_REG] ? ref_mem[res[NB_MEM_ADDR+1:2]] : res;
        e.pc_src  = cmem[MEM_BRANCH] && (res == '0);
        e.target  = pc4 + imm * 4;
        reference = e;
    endfunction

    task automatic issue(input int test, input logic [NB_CTRL_EX-1:0] cex,
                         input logic [NB_CTRL_MEM-1:0] cmem, input logic [NB_CTRL_WB-1:0] cwb,
                         input logic [NB_REG-1:0] s, input logic [NB_REG-1:0] t,
                         input logic [NB_REG-1:0] d, input logic [LEN-1:0] imm);
        expect_t             e;
        logic [LEN+NB_REG:0] w;
        // Only writes three or more instructions old have reached the register file
        while (lag_q.size() > 2)
        begin
            w = lag_q.pop_front();
            if (w[LEN+NB_REG] && w[LEN+NB_REG-1:LEN] != '0)
            begin
                reg_file[w[LEN+NB_REG-1:LEN]] = w[LEN-1:0];
            end
        end
        pc = pc + 4;
        e  = reference(cex, cmem, cwb, s, t, d, imm, pc);
        // A store's ALU result is its address
        if (cmem[MEM_WRITE])
        begin
            ref_mem[e.wb_data[NB_MEM_ADDR+1:2]] = arch_regs[t];
        end
        if (e.wb_en && e.wb_reg != '0)
        begin
            arch_regs[e.wb_reg] = e.wb_data;
        end
        lag_q.push_back({e.wb_en, e.wb_reg, e.wb_data});
        @(posedge clk);
        adder_id    <= pc;
        dato1       <= reg_file[s];
        dato2       <= reg_file[t];
        sign_extend <= imm;
        rs          <= s;
        rt          <= t;
        rd          <= d;
        ctrl_ex     <= cex;
        ctrl_mem    <= cmem;
        ctrl_wb     <= cwb;
        exp_valid   <= 1'b1;
        exp_test    <= 8'(test);
        exp         <= e;
    endtask

    task automatic bubble(input int test);
        issue(test, '0, '0, '0, '0, '0, '0, '0);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial
    begin
        logic [LEN-1:0]    addrs [6];
        logic [NB_REG-1:0] d1;
        logic [NB_REG-1:0] d2;
        logic [NB_REG-1:0] s;
        int                waited;
        lfsr_state  = 32'h51e5;
        pc          = '0;
        rst         = 1'b0;
        // A live instruction sits on the inputs while reset is low
        adder_id    = 32'h0000_0100;
        dato1       = 32'h0000_1234;
        dato2       = 32'h0000_1234;
        sign_extend = 32'h0000_0010;
        rs          = '0;
        rt          = '0;
        rd          = 5'd3;
        ctrl_ex     = {2'b10, ALU_ADD};
        ctrl_mem    = 3'b100;
        ctrl_wb     = 2'b10;
        exp_valid   = 1'b0;
        exp_test    = '0;
        exp         = '0;
        for (int i = 0; i < 32; i++)
        begin
            arch_regs[i] = (i == 0) ? '0 : take_bits(32);
            reg_file[i]  = arch_regs[i];
        end
        for (int i = 0; i < 2**NB_MEM_ADDR; i++)
        begin
            ref_mem[i] = '0;
        end
        // Stage registers read back as zero once the first falling edge has passed
        @(posedge clk);
        exp_valid <= 1'b1;
        @(posedge clk);
        // Equal operands would raise the branch flag without reset
        ctrl_ex <= {2'b10, ALU_SUB};
        repeat (2) @(posedge clk);
        rst         <= 1'b1;
        adder_id    <= '0;
        dato1       <= '0;
        dato2       <= '0;
        sign_extend <= '0;
        rd          <= '0;
        ctrl_ex     <= '0;
        ctrl_mem    <= '0;
        ctrl_wb     <= '0;

        repeat (3) bubble(0);
        // Register type with RegDst set
        for (int i = 0; i < 30; i++)
        begin
            issue(1, {2'b10, all_ops[i / 3]}, 3'b000, 2'b10, rand_reg(), rand_reg(), rand_reg(),
                  rand_imm());
        end
        // Immediate type with ALUSrc set
        repeat (12) issue(2, {2'b01, all_ops[take_bits(4) % 10]}, 3'b000, 2'b10,
                          rand_reg(), rand_reg(), rand_reg(), rand_imm());
        for (int i = 0; i < 8; i++)
        begin
            s = rand_reg();
            issue(3, {2'b00, ALU_SUB}, 3'b100, 2'b00, s, (i % 2 == 0) ? s : rand_reg(),
                  rand_reg(), rand_imm());
        end
        for (int i = 0; i < 6; i++)
        begin
            addrs[i] = take_bits(NB_MEM_ADDR) << 2;
            issue(4, {2'b01, ALU_ADD}, 3'b001, 2'b00, '0, rand_reg(), '0, addrs[i]);
        end
        // Bubble after each load keeps load-use out of the stream
        for (int i = 0; i < 6; i++)
        begin
            issue(4, {2'b01, ALU_ADD}, 3'b010, 2'b11, '0, rand_reg(), '0, addrs[i]);
            bubble(4);
        end

        // Chains at distance one on rs and distance two on rt
        d1 = rand_reg();
        d2 = rand_reg();
        for (int i = 0; i < 12; i++)
        begin
            s = rand_reg();
            issue(5, {2'b10, all_ops[take_bits(4) % 10]}, 3'b000, 2'b10, d1, d2, s, '0);
            d2 = d1;
            d1 = s;
        end
        // Register 0 result must not be forwarded
        issue(5, {2'b10, ALU_ADD}, 3'b000, 2'b10, 5'd1, 5'd2, 5'd0, '0);
        issue(5, {2'b10, ALU_OR}, 3'b000, 2'b10, 5'd0, 5'd3, 5'd4, '0);
        issue(5, {2'b10, ALU_ADD}, 3'b000, 2'b10, 5'd0, 5'd0, 5'd5, '0);
        // Both stages hold r9 and the newer one wins
        issue(5, {2'b10, ALU_XOR}, 3'b000, 2'b10, 5'd6, 5'd7, 5'd9, '0);
        issue(5, {2'b10, ALU_SUB}, 3'b000, 2'b10, 5'd8, 5'd6, 5'd9, '0);
        issue(5, {2'b10, ALU_ADD}, 3'b000, 2'b10, 5'd9, 5'd9, 5'd10, '0);
        bubble(NUM_TESTS);

        waited = 0;
        while (tests_done < NUM_TESTS && waited < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            waited++;
        end
        if (tests_done < NUM_TESTS)
        begin
            $display("Timeout: expected writebacks were never checked");
        end
        $display("Summary: %0d of %0d tests done, %0d failed, %0d checks, %0d errors",
                 tests_done, NUM_TESTS, tests_failed, checks, errors);
        if (tests_done == NUM_TESTS && tests_failed == 0 && errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
src/mips_pkg.sv
src/alu.sv
src/forwarding_unit.sv
src/tl_execute.sv
src/tl_memory.sv
src/tl_back_end.sv
dv/back_end_checker.sv
dv/tb_back_end.sv

// File: src/alu.sv
`default_nettype none

module alu
    import mips_pkg::*;
#(
    parameter int LEN = 32
)
(
    input  wire [LEN-1:0]            i_dato_a,
    input  wire [LEN-1:0]            i_dato_b,
    input  wire [NB_ALU_CONTROL-1:0] i_opcode,
    output logic [LEN-1:0]           o_result,
    output logic                     o_zero_flag
);

    // Shift amount comes from the low bits of A
    localparam int NB_SHAMT = 5;

    logic [NB_SHAMT-1:0] shamt;
    logic                less_than;

    assign shamt     = i_dato_a[NB_SHAMT-1:0];
    assign less_than = $signed(i_dato_a) < $signed(i_dato_b);

    always_comb
    begin
        case (i_opcode)
            ALU_ADD:
                o_result = i_dato_a + i_dato_b;
            ALU_SUB:
                o_result = i_dato_a - i_dato_b;
            ALU_AND:
                o_result = i_dato_a & i_dato_b;
            ALU_OR:
                o_result = i_dato_a | i_dato_b;
            ALU_XOR:
                o_result = i_dato_a ^ i_dato_b;
            ALU_NOR:
                o_result = ~(i_dato_a | i_dato_b);
            ALU_SLT:
                o_result = {{(LEN-1){1'b0}}, less_than};
            ALU_SLL:
                o_result = i_dato_b << shamt;
            ALU_SRL:
                o_result = i_dato_b >> shamt;
            // Immediate moved into the upper half
            ALU_LUI:
                o_result = {i_dato_b[LEN/2-1:0], {(LEN/2){1'b0}}};
            default:
                o_result = '0;
        endcase
    end

    assign o_zero_flag = (o_result == '0);

endmodule

`default_nettype wire

// File: src/forwarding_unit.sv
`default_nettype none

module forwarding_unit
    import mips_pkg::*;
#(
    parameter int NB_ADDRESS_REGISTROS = 5
)
(
    input  wire [NB_ADDRESS_REGISTROS-1:0] i_rs,
    input  wire [NB_ADDRESS_REGISTROS-1:0] i_rt,
    input  wire [NB_ADDRESS_REGISTROS-1:0] i_exmem_write_reg,
    input  wire                            i_exmem_reg_write,
    input  wire [NB_ADDRESS_REGISTROS-1:0] i_memwb_write_reg,
    input  wire                            i_memwb_reg_write,
    output logic [1:0]                     o_fwd_a,
    output logic [1:0]                     o_fwd_b
);

    // Newest producer wins, register 0 is never a producer
    function automatic logic [1:0] fwd_select(input logic [NB_ADDRESS_REGISTROS-1:0] src);
        logic hit_exmem;
        logic hit_memwb;
        hit_exmem = i_exmem_reg_write && (i_exmem_write_reg != '0)
                    && (i_exmem_write_reg == src);
        hit_memwb = i_memwb_reg_write && (i_memwb_write_reg != '0)
                    && (i_memwb_write_reg == src);
        if (hit_exmem)
        begin
            fwd_select = FWD_EXMEM;
        end
        else if (hit_memwb)
        begin
            fwd_select = FWD_MEMWB;
        end
        else
        begin
            fwd_select = FWD_REG;
        end
    endfunction

    always_comb
    begin
        o_fwd_a = fwd_select(i_rs);
        o_fwd_b = fwd_select(i_rt);
    end

endmodule

`default_nettype wire

// File: src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////////////////////////
    // Control field widths
    ////////////////////////////////////////////////////////////
    localparam int NB_ALU_CONTROL = 4;
    localparam int NB_CTRL_EX     = 6;
    localparam int NB_CTRL_MEM    = 3;
    localparam int NB_CTRL_WB     = 2;

    ////////////////////////////////////////////////////////////
    // ALU operation codes
    ////////////////////////////////////////////////////////////
    localparam logic [NB_ALU_CONTROL-1:0] ALU_ADD = 4'h0;
    localparam logic [NB_ALU_CONTROL-1:0] ALU_SUB = 4'h1;
    localparam logic [NB_ALU_CONTROL-1:0] ALU_AND = 4'h2;
    localparam logic [NB_ALU_CONTROL-1:0] ALU_OR  = 4'h3;
    localparam logic [NB_ALU_CONTROL-1:0] ALU_XOR = 4'h4;
    localparam logic [NB_ALU_CONTROL-1:0] ALU_NOR = 4'h5;
    localparam logic [NB_ALU_CONTROL-1:0] ALU_SLT = 4'h6;
    localparam logic [NB_ALU_CONTROL-1:0] ALU_SLL = 4'h7;
    localparam logic [NB_ALU_CONTROL-1:0] ALU_SRL = 4'h8;
    localparam logic [NB_ALU_CONTROL-1:0] ALU_LUI = 4'h9;

    // Execute field: RegDst, ALUSrc, then the ALU code
    localparam int EX_REG_DST = 5;
    localparam int EX_ALU_SRC = 4;
    localparam int EX_ALU_MSB = 3;
    localparam int EX_ALU_LSB = 0;

    // Memory field
    localparam int MEM_BRANCH = 2;
    localparam int MEM_READ   = 1;
    localparam int MEM_WRITE  = 0;

    // Writeback field
    localparam int WB_REG_WRITE  = 1;
    localparam int WB_MEM_TO_REG = 0;

    // Operand source selects from the forwarding unit
    localparam logic [1:0] FWD_REG   = 2'b00;
    localparam logic [1:0] FWD_MEMWB = 2'b01;
    localparam logic [1:0] FWD_EXMEM = 2'b10;

endpackage

`default_nettype wire

// File: src/tl_back_end.sv
`default_nettype none

module tl_back_end
    import mips_pkg::*;
#(
    parameter int LEN                  = 32,
    parameter int NB_ADDRESS_REGISTROS = 5,
    parameter int NB_MEM_ADDR          = 6
)
(
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire [LEN-1:0]                   i_adder_id,
    input  wire [LEN-1:0]                   i_dato1,
    input  wire [LEN-1:0]                   i_dato2,
    input  wire [LEN-1:0]                   i_sign_extend,
    input  wire [NB_ADDRESS_REGISTROS-1:0]  i_rs,
    input  wire [NB_ADDRESS_REGISTROS-1:0]  i_rt,
    input  wire [NB_ADDRESS_REGISTROS-1:0]  i_rd,
    input  wire [NB_CTRL_EX-1:0]            i_ctrl_ex,
    input  wire [NB_CTRL_MEM-1:0]           i_ctrl_mem,
    input  wire [NB_CTRL_WB-1:0]            i_ctrl_wb,
    output logic [LEN-1:0]                  o_wb_data,
    output logic [NB_ADDRESS_REGISTROS-1:0] o_wb_reg,
    output logic                            o_wb_en,
    output logic                            o_pc_src,
    output logic [LEN-1:0]                  o_branch_target
);

    // EX/MEM stage register contents
    logic [LEN-1:0]                  exmem_alu_result;
    logic [LEN-1:0]                  exmem_dato2;
    logic [LEN-1:0]                  exmem_add_execute;
    logic                            exmem_alu_zero;
    logic [NB_ADDRESS_REGISTROS-1:0] exmem_write_reg;
    logic [NB_CTRL_MEM-1:0]          exmem_ctrl_mem;
    logic [NB_CTRL_WB-1:0]           exmem_ctrl_wb;

    tl_execute #(
        .LEN                  (LEN),
        .NB_ADDRESS_REGISTROS (NB_ADDRESS_REGISTROS)
    ) u_tl_execute (
        .i_clk               (i_clk),
        .i_rst               (i_rst),
        .i_adder_id          (i_adder_id),
        .i_dato1             (i_dato1),
        .i_dato2             (i_dato2),
        .i_sign_extend       (i_sign_extend),
        .i_rs                (i_rs),
        .i_rt                (i_rt),
        .i_rd                (i_rd),
        .i_ctrl_ex           (i_ctrl_ex),
        .i_ctrl_mem          (i_ctrl_mem),
        .i_ctrl_wb           (i_ctrl_wb),
        // MEM/WB values fed back for forwarding
        .i_wb_data           (o_wb_data),
        .i_wb_reg            (o_wb_reg),
        .i_wb_en             (o_wb_en),
        .o_exmem_alu_result  (exmem_alu_result),
        .o_exmem_dato2       (exmem_dato2),
        .o_exmem_add_execute (exmem_add_execute),
        .o_exmem_alu_zero    (exmem_alu_zero),
        .o_exmem_write_reg   (exmem_write_reg),
        .o_exmem_ctrl_mem    (exmem_ctrl_mem),
        .o_exmem_ctrl_wb     (exmem_ctrl_wb)
    );

    tl_memory #(
        .LEN                  (LEN),
        .NB_ADDRESS_REGISTROS (NB_ADDRESS_REGISTROS),
        .NB_MEM_ADDR          (NB_MEM_ADDR)
    ) u_tl_memory (
        .i_clk               (i_clk),
        .i_rst               (i_rst),
        .i_exmem_alu_result  (exmem_alu_result),
        .i_exmem_dato2       (exmem_dato2),
        .i_exmem_add_execute (exmem_add_execute),
        .i_exmem_alu_zero    (exmem_alu_zero),
        .i_exmem_write_reg   (exmem_write_reg),
        .i_exmem_ctrl_mem    (exmem_ctrl_mem),
        .i_exmem_ctrl_wb     (exmem_ctrl_wb),
        .o_wb_data           (o_wb_data),
        .o_wb_reg            (o_wb_reg),
        .o_wb_en             (o_wb_en),
        .o_pc_src            (o_pc_src),
        .o_branch_target     (o_branch_target)
    );

endmodule

`default_nettype wire

// File: src/tl_execute.sv
`default_nettype none

module tl_execute
    import mips_pkg::*;
#(
    parameter int LEN                  = 32,
    parameter int NB_ADDRESS_REGISTROS = 5
)
(
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire [LEN-1:0]                   i_adder_id,
    input  wire [LEN-1:0]                   i_dato1,
    input  wire [LEN-1:0]                   i_dato2,
    input  wire [LEN-1:0]                   i_sign_extend,
    input  wire [NB_ADDRESS_REGISTROS-1:0]  i_rs,
    input  wire [NB_ADDRESS_REGISTROS-1:0]  i_rt,
    input  wire [NB_ADDRESS_REGISTROS-1:0]  i_rd,
    input  wire [NB_CTRL_EX-1:0]            i_ctrl_ex,
    input  wire [NB_CTRL_MEM-1:0]           i_ctrl_mem,
    input  wire [NB_CTRL_WB-1:0]            i_ctrl_wb,
    input  wire [LEN-1:0]                   i_wb_data,
    input  wire [NB_ADDRESS_REGISTROS-1:0]  i_wb_reg,
    input  wire                             i_wb_en,
    output logic [LEN-1:0]                  o_exmem_alu_result,
    output logic [LEN-1:0]                  o_exmem_dato2,
    output logic [LEN-1:0]                  o_exmem_add_execute,
    output logic                            o_exmem_alu_zero,
    output logic [NB_ADDRESS_REGISTROS-1:0] o_exmem_write_reg,
    output logic [NB_CTRL_MEM-1:0]          o_exmem_ctrl_mem,
    output logic [NB_CTRL_WB-1:0]           o_exmem_ctrl_wb
);

    logic [1:0]                      fwd_a;
    logic [1:0]                      fwd_b;
    logic [LEN-1:0]                  opnd_a;
    logic [LEN-1:0]                  opnd_b_fwd;
    logic [LEN-1:0]                  opnd_b;
    logic [NB_ADDRESS_REGISTROS-1:0] write_reg;
    logic [LEN-1:0]                  add_execute;
    logic [LEN-1:0]                  alu_result;
    logic                            alu_zero;

    function automatic logic [LEN-1:0] fwd_mux(input logic [1:0] sel,
                                               input logic [LEN-1:0] reg_val);
        case (sel)
            FWD_EXMEM: fwd_mux = o_exmem_alu_result;
            FWD_MEMWB: fwd_mux = i_wb_data;
            default:   fwd_mux = reg_val;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////
    forwarding_unit #(
        .NB_ADDRESS_REGISTROS(NB_ADDRESS_REGISTROS)
    ) u_forwarding_unit (
        .i_rs              (i_rs),
        .i_rt              (i_rt),
        .i_exmem_write_reg (o_exmem_write_reg),
        .i_exmem_reg_write (o_exmem_ctrl_wb[WB_REG_WRITE]),
        .i_memwb_write_reg (i_wb_reg),
        .i_memwb_reg_write (i_wb_en),
        .o_fwd_a           (fwd_a),
        .o_fwd_b           (fwd_b)
    );

    always_comb
    begin
        opnd_a     = fwd_mux(fwd_a, i_dato1);
        opnd_b_fwd = fwd_mux(fwd_b, i_dato2);
    end

    // ALUSrc and RegDst
    assign opnd_b    = i_ctrl_ex[EX_ALU_SRC] ? i_sign_extend : opnd_b_fwd;
    assign write_reg = i_ctrl_ex[EX_REG_DST] ? i_rd : i_rt;

    // Branch offset counted in words
    assign add_execute = i_adder_id + (i_sign_extend << 2);

    alu #(
        .LEN(LEN)
    ) u_alu (
        .i_dato_a    (opnd_a),
        .i_dato_b    (opnd_b),
        .i_opcode    (i_ctrl_ex[EX_ALU_MSB:EX_ALU_LSB]),
        .o_result    (alu_result),
        .o_zero_flag (alu_zero)
    );

    ////////////////////////////////////////////////////////////
    // EX/MEM register, falling edge
    ////////////////////////////////////////////////////////////
    always_ff @(negedge i_clk)
    begin
        if (!i_rst)
        begin
            o_exmem_alu_result  <= '0;
            o_exmem_dato2       <= '0;
            o_exmem_add_execute <= '0;
            o_exmem_alu_zero    <= 1'b0;
            o_exmem_write_reg   <= '0;
            o_exmem_ctrl_mem    <= '0;
            o_exmem_ctrl_wb     <= '0;
        end
        else
        begin
            o_exmem_alu_result  <= alu_result;
            // Store data takes the forwarded B
            o_exmem_dato2       <= opnd_b_fwd;
            o_exmem_add_execute <= add_execute;
            o_exmem_alu_zero    <= alu_zero;
            o_exmem_write_reg   <= write_reg;
            o_exmem_ctrl_mem    <= i_ctrl_mem;
            o_exmem_ctrl_wb     <= i_ctrl_wb;
        end
    end

endmodule

`default_nettype wire

// File: src/tl_memory.sv
`default_nettype none

module tl_memory
    import mips_pkg::*;
#(
    parameter int LEN                  = 32,
    parameter int NB_ADDRESS_REGISTROS = 5,
    parameter int NB_MEM_ADDR          = 6
)
(
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire [LEN-1:0]                   i_exmem_alu_result,
    input  wire [LEN-1:0]                   i_exmem_dato2,
    input  wire [LEN-1:0]                   i_exmem_add_execute,
    input  wire                             i_exmem_alu_zero,
    input  wire [NB_ADDRESS_REGISTROS-1:0]  i_exmem_write_reg,
    input  wire [NB_CTRL_MEM-1:0]           i_exmem_ctrl_mem,
    input  wire [NB_CTRL_WB-1:0]            i_exmem_ctrl_wb,
    output logic [LEN-1:0]                  o_wb_data,
    output logic [NB_ADDRESS_REGISTROS-1:0] o_wb_reg,
    output logic                            o_wb_en,
    output logic                            o_pc_src,
    output logic [LEN-1:0]                  o_branch_target
);

    localparam int MEM_DEPTH = 2 ** NB_MEM_ADDR;

    logic [LEN-1:0]         data_mem [MEM_DEPTH];
    logic [NB_MEM_ADDR-1:0] mem_addr;
    logic [LEN-1:0]         read_data;
    logic [LEN-1:0]         memwb_read_data;
    logic [LEN-1:0]         memwb_alu_result;
    logic [NB_CTRL_WB-1:0]  memwb_ctrl_wb;

    // Word address, byte offset dropped
    assign mem_addr  = i_exmem_alu_result[NB_MEM_ADDR+1:2];
    assign read_data = i_exmem_ctrl_mem[MEM_READ] ? data_mem[mem_addr] : '0;

    // Branch resolves here, one cycle after execute
    assign o_pc_src        = i_exmem_ctrl_mem[MEM_BRANCH] & i_exmem_alu_zero;
    assign o_branch_target = i_exmem_add_execute;

    ////////////////////////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////////////////////////
    always_ff @(negedge i_clk)
    begin
        if (!i_rst)
        begin
            for (int i = 0; i < MEM_DEPTH; i++)
            begin
                data_mem[i] <= '0;
            end
        end
        else if (i_exmem_ctrl_mem[MEM_WRITE])
        begin
            data_mem[mem_addr] <= i_exmem_dato2;
        end
    end

    // MEM/WB register
    always_ff @(negedge i_clk)
    begin
        if (!i_rst)
        begin
            memwb_read_data  <= '0;
            memwb_alu_result <= '0;
            memwb_ctrl_wb    <= '0;
            o_wb_reg         <= '0;
        end
        else
        begin
            memwb_read_data  <= read_data;
            memwb_alu_result <= i_exmem_alu_result;
            memwb_ctrl_wb    <= i_exmem_ctrl_wb;
            o_wb_reg         <= i_exmem_write_reg;
        end
    end

    assign o_wb_data = memwb_ctrl_wb[WB_MEM_TO_REG] ? memwb_read_data : memwb_alu_result;
    assign o_wb_en   = memwb_ctrl_wb[WB_REG_WRITE];

endmodule

`default_nettype wire
